// ==== rtl/dsp_rx_pkg.sv ====
package dsp_rx_pkg;

    // Width of one assembled audio word
    parameter int SAMPLE_W = 32;

    // Width of the configuration fields and the bit and offset counters
    parameter int CNT_W = 5;

    // One right-justified, zero-extended audio word
    typedef logic [SAMPLE_W-1:0] sample_t;

    // Bit index within a word
    // Also used for the word length, stored as length minus one
    typedef logic [CNT_W-1:0] bit_cnt_t;

    // Bit periods between the frame pulse and the first data bit
    typedef logic [CNT_W-1:0] offset_t;

    // Frame sync FSM states
    typedef enum logic [1:0] {
        SYNC_IDLE,
        SYNC_OFFSET,
        SYNC_RUN
    } sync_state_t;

endpackage

// ==== rtl/dsp_rx_frame_sync.sv ====
module dsp_rx_frame_sync (
    input  logic                  sck_i,
    input  logic                  rstn_i,

    input  logic                  cfg_en_i,
    input  logic                  ws_i,
    input  dsp_rx_pkg::offset_t   cfg_offset_i,
    input  dsp_rx_pkg::bit_cnt_t  cfg_word_len_i,

    output logic                  sample_en_o,
    output logic                  word_first_o,
    output logic                  word_last_o
);

    import dsp_rx_pkg::*;

    sync_state_t state;
    sync_state_t next_state;

    // Edges seen since the frame pulse, only counts in SYNC_OFFSET
    offset_t     off_cnt;

    // Index of the bit sampled on the current edge, zero outside run
    bit_cnt_t    bit_cnt;

    logic        sample_en;
    logic        word_last;

    // Next state and sample strobe
    always_comb begin
        next_state = state;
        sample_en  = 1'b0;

        case (state)
            SYNC_IDLE: begin
                if (ws_i) begin
                    if (cfg_offset_i == '0) begin
                        // Data starts on the same edge as the pulse
                        next_state = SYNC_RUN;
                        sample_en  = 1'b1;
                    end else begin
                        next_state = SYNC_OFFSET;
                    end
                end
            end
            SYNC_OFFSET: begin
                if (off_cnt == cfg_offset_i) begin
                    next_state = SYNC_RUN;
                    sample_en  = 1'b1;
                end
            end
            SYNC_RUN: begin
                // Synced once per enable, words follow with no gap
                sample_en = 1'b1;
            end
            default: begin
                next_state = SYNC_IDLE;
            end
        endcase

        if (!cfg_en_i) begin
            next_state = SYNC_IDLE;
            sample_en  = 1'b0;
        end
    end

    assign word_last    = sample_en && (bit_cnt == cfg_word_len_i);
    assign sample_en_o  = sample_en;
    assign word_first_o = sample_en && (bit_cnt == '0);
    assign word_last_o  = word_last;

    always_ff @(posedge sck_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state   <= SYNC_IDLE;
            off_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            state <= next_state;

            if (next_state == SYNC_OFFSET) begin
                off_cnt <= off_cnt + 1'b1;
            end else begin
                off_cnt <= '0;
            end

            if (next_state == SYNC_IDLE) begin
                bit_cnt <= '0;
            end else if (sample_en) begin
                // Wrap at the configured length
                bit_cnt <= word_last ? '0 : bit_cnt + 1'b1;
            end
        end
    end

    // Offset count must stop at the configured offset and hand over to run
    a_offset_bound: assert property (
        @(posedge sck_i) disable iff (!rstn_i)
        (state == SYNC_OFFSET) |-> (off_cnt <= cfg_offset_i)
    ) else $error("offset counter ran past cfg_offset_i");

    // Only a one-bit word can end before the FSM reaches run
    a_last_in_run: assert property (
        @(posedge sck_i) disable iff (!rstn_i)
        word_last_o |-> (state == SYNC_RUN) || (cfg_word_len_i == '0)
    ) else $error("word boundary outside run state");

endmodule

// ==== rtl/dsp_rx_shifter.sv ====
module dsp_rx_shifter (
    input  logic                  sck_i,
    input  logic                  rstn_i,

    input  logic                  sd_i,
    input  logic                  sample_en_i,
    input  logic                  word_first_i,
    input  logic                  word_last_i,
    input  logic                  cfg_lsb_first_i,
    input  dsp_rx_pkg::bit_cnt_t  cfg_word_len_i,

    output dsp_rx_pkg::sample_t   word_o
);

    import dsp_rx_pkg::*;

    sample_t  shreg;
    sample_t  shift_base;
    sample_t  shift_nxt;
    sample_t  word_nxt;

    // LSB-first words sit at the top of the register when complete
    bit_cnt_t rjust_sh;

    always_comb begin
        // A new word starts from an empty register
        shift_base = word_first_i ? '0 : shreg;

        if (cfg_lsb_first_i) begin
            shift_nxt = {sd_i, shift_base[SAMPLE_W-1:1]};
        end else begin
            shift_nxt = {shift_base[SAMPLE_W-2:0], sd_i};
        end
    end

    assign rjust_sh = bit_cnt_t'(SAMPLE_W - 1) - cfg_word_len_i;

    // MSB-first words are already right-justified
    assign word_nxt = cfg_lsb_first_i ? (shift_nxt >> rjust_sh) : shift_nxt;

    always_ff @(posedge sck_i) begin
        if (sample_en_i) begin
            shreg <= shift_nxt;
        end
    end

    // Completed word, held until the next word ends
    always_ff @(posedge sck_i or negedge rstn_i) begin
        if (!rstn_i) begin
            word_o <= '0;
        end else if (word_last_i) begin
            word_o <= word_nxt;
        end
    end

endmodule

// ==== rtl/dsp_rx_word_out.sv ====
module dsp_rx_word_out (
    input  logic                  sck_i,
    input  logic                  rstn_i,

    input  logic                  cfg_en_i,
    input  logic                  cfg_2ch_i,
    input  logic                  word_done_i,
    input  logic                  ready_i,

    input  dsp_rx_pkg::sample_t   ch0_word_i,
    input  dsp_rx_pkg::sample_t   ch1_word_i,

    output dsp_rx_pkg::sample_t   data_o,
    output logic                  valid_o,
    output logic                  overrun_o
);

    import dsp_rx_pkg::*;

    // Shifter words settle one edge after the boundary
    logic    done_q;

    sample_t hold0;
    sample_t hold1;
    logic    pend0;
    logic    pend1;

    logic    xfer;
    logic    pend0_left;
    logic    pend1_left;
    logic    load;
    logic    collide;
    logic    overrun;

    assign xfer = valid_o && ready_i;

    // Pending flags as they stand after this edge's transfer
    // Channel 0 is always offered before channel 1
    assign pend0_left = pend0 && !xfer;
    assign pend1_left = pend1 && !(xfer && !pend0);

    // A new pair is taken only when the old one has fully left
    assign load    = done_q && cfg_en_i && !(pend0_left || pend1_left);
    assign collide = done_q && cfg_en_i && (pend0_left || pend1_left);

    assign valid_o   = pend0 || pend1;
    assign data_o    = pend0 ? hold0 : hold1;
    assign overrun_o = overrun;

    always_ff @(posedge sck_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_q  <= 1'b0;
            pend0   <= 1'b0;
            pend1   <= 1'b0;
            overrun <= 1'b0;
        end else begin
            done_q <= word_done_i;

            if (load) begin
                pend0 <= 1'b1;
                pend1 <= cfg_2ch_i;
            end else begin
                pend0 <= pend0_left;
                pend1 <= pend1_left;
            end

            // Sticky until the receiver is disabled
            if (!cfg_en_i) begin
                overrun <= 1'b0;
            end else if (collide) begin
                overrun <= 1'b1;
            end
        end
    end

    always_ff @(posedge sck_i) begin
        if (load) begin
            hold0 <= ch0_word_i;
            hold1 <= ch1_word_i;
        end
    end

    // Stream rule, an offered word holds until it is taken
    a_hold_stable: assert property (
        @(posedge sck_i) disable iff (!rstn_i)
        (valid_o && !ready_i) |=> (valid_o && $stable(data_o))
    ) else $error("data_o changed or valid_o dropped under back-pressure");

endmodule

// ==== rtl/dsp_rx_top.sv ====
module dsp_rx_top (
    input  logic                  sck_i,
    input  logic                  rstn_i,

    // Serial lines from the codec
    input  logic                  ws_i,
    input  logic                  sd0_i,
    input  logic                  sd1_i,

    // Configuration, stable while enabled
    input  logic                  cfg_en_i,
    input  logic                  cfg_2ch_i,
    input  logic                  cfg_lsb_first_i,
    input  dsp_rx_pkg::bit_cnt_t  cfg_word_len_i,
    input  dsp_rx_pkg::offset_t   cfg_offset_i,

    // Word stream
    input  logic                  ready_i,
    output dsp_rx_pkg::sample_t   data_o,
    output logic                  valid_o,
    output logic                  overrun_o
);

    import dsp_rx_pkg::*;

    logic    sample_en;
    logic    word_first;
    logic    word_last;

    sample_t ch0_word;
    sample_t ch1_word;

    dsp_rx_frame_sync u_sync (
        .sck_i          (sck_i),
        .rstn_i         (rstn_i),
        .cfg_en_i       (cfg_en_i),
        .ws_i           (ws_i),
        .cfg_offset_i   (cfg_offset_i),
        .cfg_word_len_i (cfg_word_len_i),
        .sample_en_o    (sample_en),
        .word_first_o   (word_first),
        .word_last_o    (word_last)
    );

    // Both lines always run, channel use is decided at the output
    dsp_rx_shifter u_shift0 (
        .sck_i           (sck_i),
        .rstn_i          (rstn_i),
        .sd_i            (sd0_i),
        .sample_en_i     (sample_en),
        .word_first_i    (word_first),
        .word_last_i     (word_last),
        .cfg_lsb_first_i (cfg_lsb_first_i),
        .cfg_word_len_i  (cfg_word_len_i),
        .word_o          (ch0_word)
    );

    dsp_rx_shifter u_shift1 (
        .sck_i           (sck_i),
        .rstn_i          (rstn_i),
        .sd_i            (sd1_i),
        .sample_en_i     (sample_en),
        .word_first_i    (word_first),
        .word_last_i     (word_last),
        .cfg_lsb_first_i (cfg_lsb_first_i),
        .cfg_word_len_i  (cfg_word_len_i),
        .word_o          (ch1_word)
    );

    dsp_rx_word_out u_out (
        .sck_i       (sck_i),
        .rstn_i      (rstn_i),
        .cfg_en_i    (cfg_en_i),
        .cfg_2ch_i   (cfg_2ch_i),
        .word_done_i (word_last),
        .ready_i     (ready_i),
        .ch0_word_i  (ch0_word),
        .ch1_word_i  (ch1_word),
        .data_o      (data_o),
        .valid_o     (valid_o),
        .overrun_o   (overrun_o)
    );

endmodule

// ==== test/dsp_rx_codec_model.sv ====
module dsp_rx_codec_model (
    input  logic sck_i,
    output logic ws_o,
    output logic sd0_o,
    output logic sd1_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import dsp_rx_pkg::*;

    // Words waiting to be serialized, one queue per data line
    sample_t ch0_q[$];
    sample_t ch1_q[$];

    initial begin
        ws_o  = 1'b0;
        sd0_o = 1'b0;
        sd1_o = 1'b0;
    end

    task automatic add_pair(input sample_t w0, input sample_t w1);
        ch0_q.push_back(w0);
        ch1_q.push_back(w1);
    endtask

    // Lines change 10 ns after the rising edge, away from the sampling edge
    task automatic drive_bit(input logic ws, input logic b0, input logic b1);
        @(posedge sck_i);
        #10;
        ws_o  = ws;
        sd0_o = b0;
        sd1_o = b1;
    endtask

    // One frame pulse, offset filler bits, then all queued words back to back
    task automatic send_frame(input int offset, input int len, input logic lsb_first);
        sample_t w0;
        sample_t w1;
        logic    pulse;
        int      k;
        int      idx;

        pulse = 1'b1;

        // Filler is driven high so a wrong offset corrupts the words
        for (k = 0; k < offset; k++) begin
            drive_bit(pulse, 1'b1, 1'b1);
            pulse = 1'b0;
        end

        while (ch0_q.size() > 0) begin
            w0 = ch0_q.pop_front();
            w1 = ch1_q.pop_front();
            for (k = 0; k < len; k++) begin
                idx = lsb_first ? k : len - 1 - k;
                drive_bit(pulse, w0[idx], w1[idx]);
                pulse = 1'b0;
            end
        end
    endtask

endmodule

// ==== test/tb_dsp_rx.sv ====
module tb_dsp_rx;

    timeunit 1ns;
    timeprecision 1ps;

    import dsp_rx_pkg::*;

    localparam logic [15:0] LFSR_SEED     = 16'd19731;
    localparam logic [15:0] LFSR_TAPS     = 16'hB400;
    localparam int          RESET_CYCLES  = 5;
    localparam int          DRAIN_TIMEOUT = 300;
    localparam int          OVR_TIMEOUT   = 120;

    logic     sck_i = 1'b0;
    logic     rstn_i;
    logic     ws_i;
    logic     sd0_i;
    logic     sd1_i;
    logic     cfg_en_i;
    logic     cfg_2ch_i;
    logic     cfg_lsb_first_i;
    bit_cnt_t cfg_word_len_i;
    offset_t  cfg_offset_i;
    logic     ready_i;
    sample_t  data_o;
    logic     valid_o;
    logic     overrun_o;

    logic [15:0] lfsr;

    // Expected words in output order and the head as seen by the checks
    sample_t exp_q[$];
    sample_t exp_head = '0;
    logic    exp_avail = 1'b0;

    logic quiet_chk = 1'b0;
    logic ovr_allowed = 1'b0;

    int err_cnt = 0;
    int err_base = 0;
    int test_cnt = 0;
    int words_seen = 0;

    always #50 sck_i = ~sck_i;

    dsp_rx_top dut0 (
        .sck_i           (sck_i),
        .rstn_i          (rstn_i),
        .ws_i            (ws_i),
        .sd0_i           (sd0_i),
        .sd1_i           (sd1_i),
        .cfg_en_i        (cfg_en_i),
        .cfg_2ch_i       (cfg_2ch_i),
        .cfg_lsb_first_i (cfg_lsb_first_i),
        .cfg_word_len_i  (cfg_word_len_i),
        .cfg_offset_i    (cfg_offset_i),
        .ready_i         (ready_i),
        .data_o          (data_o),
        .valid_o         (valid_o),
        .overrun_o       (overrun_o)
    );

    dsp_rx_codec_model codec0 (
        .sck_i (sck_i),
        .ws_o  (ws_i),
        .sd0_o (sd0_i),
        .sd1_o (sd1_i)
    );

    // Mid-cycle, valid_o and ready_i already decide the next edge's transfer
    always @(negedge sck_i) begin
        exp_avail = (exp_q.size() > 0);
        exp_head  = exp_avail ? exp_q[0] : '0;
        if (rstn_i && valid_o && ready_i) begin
            words_seen++;
            if (exp_avail) begin
                void'(exp_q.pop_front());
            end
        end
    end

    a_expected: assert property (
        @(posedge sck_i) disable iff (!rstn_i)
        (valid_o && ready_i) |-> exp_avail
    ) else begin
        $display("Word %08h left the DUT while no word was expected", $sampled(data_o));
        err_cnt++;
    end

    a_data: assert property (
        @(posedge sck_i) disable iff (!rstn_i)
        (valid_o && ready_i && exp_avail) |-> (data_o == exp_head)
    ) else begin
        $display("Mismatch data_o: expected %08h, got %08h",
                 $sampled(exp_head), $sampled(data_o));
        err_cnt++;
    end

    a_hold: assert property (
        @(posedge sck_i) disable iff (!rstn_i)
        (valid_o && !ready_i) |=> (valid_o && $stable(data_o))
    ) else begin
        $display("Offered word changed or was withdrawn while ready_i was low");
        err_cnt++;
    end

    a_quiet: assert property (
        @(posedge sck_i) disable iff (!rstn_i)
        quiet_chk |-> (!valid_o && !overrun_o)
    ) else begin
        $display("Mismatch valid_o %h overrun_o %h: both expected 0",
                 $sampled(valid_o), $sampled(overrun_o));
        err_cnt++;
    end

    a_no_overrun: assert property (
        @(posedge sck_i) disable iff (!rstn_i)
        !ovr_allowed |-> !overrun_o
    ) else begin
        $display("Mismatch overrun_o: expected 0, got %h", $sampled(overrun_o));
        err_cnt++;
    end

    a_ovr_clear: assert property (
        @(posedge sck_i) disable iff (!rstn_i)
        !cfg_en_i |=> !overrun_o
    ) else begin
        $display("Mismatch overrun_o: expected 0 after disable, got %h", $sampled(overrun_o));
        err_cnt++;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit, so the word holds exactly len bits
    function automatic sample_t rand_word(input int len);
        sample_t w;
        int      i;

        w = '0;
        for (i = 0; i < len; i++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[SAMPLE_W-2:0], lfsr[0]};
        end
        return w;
    endfunction

    task automatic to_drive_point();
        @(posedge sck_i);
        #10;
    endtask

    task automatic configure_rx(input logic two_ch, input int len, input logic lsb,
                                input int offset);
        to_drive_point();
        cfg_2ch_i       = two_ch;
        cfg_word_len_i  = bit_cnt_t'(len - 1);
        cfg_lsb_first_i = lsb;
        cfg_offset_i    = offset_t'(offset);
        cfg_en_i        = 1'b1;
    endtask

    task automatic disable_rx();
        cfg_en_i = 1'b0;
        to_drive_point();
        to_drive_point();
    endtask

    task automatic wait_drain();
        int cycles;

        cycles = 0;
        while (exp_q.size() > 0 || valid_o) begin
            if (cycles == DRAIN_TIMEOUT) begin
                $display("Timed out with %0d expected words never delivered", exp_q.size());
                err_cnt++;
                exp_q.delete();
                break;
            end
            to_drive_point();
            cycles++;
        end
    endtask

    task automatic wait_overrun();
        int cycles;

        cycles = 0;
        do begin
            to_drive_point();
            cycles++;
        end while (!overrun_o && cycles < OVR_TIMEOUT);
        if (!overrun_o) begin
            $display("Timed out waiting for overrun_o while ready_i was held low");
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - err_base);
        err_base = err_cnt;
    endtask

    task automatic run_stream(input int pairs, input logic two_ch, input int len,
                              input logic lsb, input int offset);
        sample_t w0;
        sample_t w1;
        int      i;

        configure_rx(two_ch, len, lsb, offset);
        for (i = 0; i < pairs; i++) begin
            w0 = rand_word(len);
            w1 = rand_word(len);
            codec0.add_pair(w0, w1);
            exp_q.push_back(w0);
            if (two_ch) begin
                exp_q.push_back(w1);
            end
        end
        codec0.send_frame(offset, len, lsb);
        wait_drain();
        disable_rx();
    endtask

    // Lines toggle with the receiver disabled, nothing may come out
    task automatic check_idle();
        int i;

        quiet_chk = 1'b1;
        for (i = 0; i < 3; i++) begin
            codec0.add_pair(rand_word(8), rand_word(8));
        end
        codec0.send_frame(2, 8, 1'b0);
        to_drive_point();
        to_drive_point();
        quiet_chk = 1'b0;
    endtask

    // Only the first of three pairs survives, the other two collide
    task automatic check_back_pressure();
        sample_t w0;
        sample_t w1;
        int      i;

        ovr_allowed = 1'b1;
        ready_i     = 1'b0;
        configure_rx(1'b1, 16, 1'b0, 0);
        for (i = 0; i < 3; i++) begin
            w0 = rand_word(16);
            w1 = rand_word(16);
            codec0.add_pair(w0, w1);
            if (i == 0) begin
                exp_q.push_back(w0);
                exp_q.push_back(w1);
            end
        end
        codec0.send_frame(0, 16, 1'b0);
        wait_overrun();
        // Release after the third pair has collided
        to_drive_point();
        ready_i = 1'b1;
        wait_drain();
        disable_rx();
        ovr_allowed = 1'b0;
    endtask

    initial begin
        rstn_i          = 1'b0;
        cfg_en_i        = 1'b0;
        cfg_2ch_i       = 1'b0;
        cfg_lsb_first_i = 1'b0;
        cfg_word_len_i  = '0;
        cfg_offset_i    = '0;
        ready_i         = 1'b1;
        lfsr            = LFSR_SEED;

        repeat (RESET_CYCLES) @(posedge sck_i);
        #10;
        rstn_i = 1'b1;

        check_idle();
        finish_test("idle after reset");

        run_stream(4, 1'b1, 16, 1'b0, 0);
        finish_test("two channels msb first 16 bit");

        run_stream(3, 1'b1, 24, 1'b1, 0);
        run_stream(4, 1'b1, 7, 1'b1, 1);
        finish_test("lsb first 24 and 7 bit");

        run_stream(3, 1'b1, 32, 1'b0, 3);
        finish_test("offset 3 with 32 bit words");

        run_stream(4, 1'b0, 12, 1'b0, 1);
        finish_test("single channel");

        check_back_pressure();
        finish_test("back-pressure and overrun");

        $display("Summary: %0d tests, %0d words checked, %0d errors",
                 test_cnt, words_seen, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/dsp_rx_pkg.sv
rtl/dsp_rx_frame_sync.sv
rtl/dsp_rx_shifter.sv
rtl/dsp_rx_word_out.sv
rtl/dsp_rx_top.sv
test/dsp_rx_codec_model.sv
test/tb_dsp_rx.sv
